/* client_accum.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// slot 1: running sum of payload bytes, mod 256
// sum includes the current byte, restarts per frame
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
module client_accum import udp_pkg::*; (
	input logic clk,
	input logic arst_n,
	client_if.accum_client pl
);

// sum of the slot 1 bytes seen so far
byte_t sum;
byte_t new_sum;
logic take;
byte_t pipe [CLIENT_LAT];

assign take = pl.pl_stb && (pl.pl_slot == SLOT_ACCUM);
// sop drops the previous frame's sum
assign new_sum = (pl.pl_sop ? 8'd0 : sum) + pl.pl_data;

always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		sum <= '0;
	end else if (take) begin
		sum <= new_sum;
	end
end

// fixed latency pipeline
always_ff @(posedge clk) begin
	pipe[0] <= new_sum;
	for (int k = 1; k < CLIENT_LAT; k++) begin
		pipe[k] <= pipe[k-1];
	end
end

assign pl.out_accum = pipe[CLIENT_LAT-1];

endmodule

/* client_count.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// slot 0: byte plus payload index, mod 256
// result CLIENT_LAT cycles after the input byte
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
module client_count import udp_pkg::*; (
	input logic clk,
	input logic arst_n,
	client_if.count_client pl
);

// index of the next payload byte
byte_t idx;
byte_t res;
logic take;
byte_t pipe [CLIENT_LAT];

assign take = pl.pl_stb && (pl.pl_slot == SLOT_COUNT);
// first byte of a frame has index 0
assign res = pl.pl_data + (pl.pl_sop ? 8'd0 : idx);

always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		idx <= '0;
	end else if (take) begin
		idx <= pl.pl_sop ? 8'd1 : idx + 8'd1;
	end
end

// fixed latency pipeline
always_ff @(posedge clk) begin
	pipe[0] <= res;
	for (int k = 1; k < CLIENT_LAT; k++) begin
		pipe[k] <= pipe[k-1];
	end
end

assign pl.out_count = pipe[CLIENT_LAT-1];

endmodule

/* client_if.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// payload bytes from the scanner delay line to the clients
// pl_slot is meaningful only while pl_stb is high
// each client answers CLIENT_LAT cycles after its input
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
interface client_if import udp_pkg::*; ();

// payload stream, driven by the scanner
byte_t pl_data;
logic pl_stb;
// first payload byte of a frame
logic pl_sop;
slot_t pl_slot;

// client results, one byte per slot
byte_t out_count;
byte_t out_accum;

modport scanner (output pl_data, pl_stb, pl_sop, pl_slot);

modport count_client (
	input pl_data, pl_stb, pl_sop, pl_slot,
	output out_count
);

modport accum_client (
	input pl_data, pl_stb, pl_sop, pl_slot,
	output out_accum
);

// framer picks the result by the delayed slot
modport framer (input pl_data, pl_stb, pl_sop, pl_slot, out_count, out_accum);

endinterface

/* flist.f */
udp_pkg.sv
client_if.sv
udp_config.sv
rx_scanner.sv
client_count.sv
client_accum.sv
tx_framer.sv
udp_blob.sv
tb_udp_blob.sv

/* run.sh */
#!/bin/sh
# build and run the udp_blob testbench with Verilator
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
	-f flist.f --top-module tb_udp_blob -o sim_udp_blob \
	|| { echo "Verilator build failed"; exit 1; }
out=$(./obj_dir/sim_udp_blob)
echo "$out"
echo "$out" | grep -qx "TESTBENCH PASSED" && exit 0 || exit 1

/* rx_scanner.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// frames need one idle cycle between them
// header checked byte by byte, decision one cycle after OFS_DECIDE
// rx_er after the decision is ignored
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
module rx_scanner import udp_pkg::*; (
	input logic clk,
	input logic arst_n,
	input byte_t rxd,
	input logic rx_dv,
	input logic rx_er,
	input logic enable_rx,
	input mac_t cfg_mac,
	input ip_t cfg_ip,
	input port_t cfg_port0,
	input port_t cfg_port1,
	client_if.scanner pl,
	output byte_t fwd_data,
	output logic fwd_en,
	output logic fwd_pl,
	output logic accept_stb,
	output logic drop_stb,
	output slot_t accept_slot
);

scan_state_e state;
// byte offset in the frame, holds at HDR_LEN
offset_t ofs;
offset_t mac_ofs, ip_ofs;
byte_t mac_byte, ip_byte;
logic hdr_ok, byte_bad, decide, accept_now;
logic [N_SLOTS-1:0] hit_hi, port_hit;
logic in_fwd, in_pl, pl_prev;

// delay line, stage 0 is the newest byte
byte_t dly_data [PIPE_LAT];
slot_t dly_slot [PIPE_LAT];
logic [PIPE_LAT-1:0] dly_fwd, dly_pl;

always_comb begin
	mac_ofs = ofs - offset_t'(OFS_DMAC);
	ip_ofs = ofs - offset_t'(OFS_DIP);
	// expected config byte for this offset, msb first
	mac_byte = byte_t'(cfg_mac >> {3'd5 - mac_ofs[2:0], 3'b000});
	ip_byte = byte_t'(cfg_ip >> {2'd3 - ip_ofs[1:0], 3'b000});
	byte_bad = rx_er || !enable_rx;
	if (mac_ofs < 6) begin
		byte_bad = byte_bad || (rxd != mac_byte);
	end else if (ofs == OFS_ETYPE) begin
		byte_bad = byte_bad || (rxd != ETYPE_HI);
	end else if (ofs == OFS_ETYPE + 1) begin
		byte_bad = byte_bad || (rxd != ETYPE_LO);
	end else if (ofs == OFS_PROTO) begin
		byte_bad = byte_bad || (rxd != PROTO_UDP);
	end else if (ip_ofs < 4) begin
		byte_bad = byte_bad || (rxd != ip_byte);
	end
	// port low byte is the decide byte itself
	port_hit[0] = hit_hi[0] && (rxd == cfg_port0[7:0]);
	port_hit[1] = hit_hi[1] && (rxd == cfg_port1[7:0]);
	decide = (state == HEADER) && rx_dv && (ofs == OFS_DECIDE);
	accept_now = decide && hdr_ok && !byte_bad && (port_hit != '0);
	in_fwd = rx_dv && ((state == FORWARD) || accept_now);
	in_pl = rx_dv && (ofs == HDR_LEN);
end

always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		state <= IDLE;
		ofs <= '0;
		hdr_ok <= 1'b0;
		hit_hi <= '0;
		accept_stb <= 1'b0;
		drop_stb <= 1'b0;
		accept_slot <= SLOT_COUNT;
	end else begin
		accept_stb <= 1'b0;
		drop_stb <= 1'b0;
		if (ofs == OFS_DPORT) begin
			hit_hi[0] <= (rxd == cfg_port0[15:8]);
			hit_hi[1] <= (rxd == cfg_port1[15:8]);
		end
		case (state)
			IDLE: begin
				if (rx_dv) begin
					state <= HEADER;
					ofs <= ofs + 1'b1;
					hdr_ok <= !byte_bad;
				end
			end
			HEADER: begin
				if (!rx_dv) begin
					// frame too short to judge
					state <= IDLE;
					ofs <= '0;
					drop_stb <= 1'b1;
				end else begin
					ofs <= ofs + 1'b1;
					hdr_ok <= hdr_ok && !byte_bad;
					if (decide) begin
						state <= accept_now ? FORWARD : DISCARD;
						accept_stb <= accept_now;
						drop_stb <= !accept_now;
						if (accept_now) begin
							accept_slot <= port_hit[0] ? SLOT_COUNT : SLOT_ACCUM;
						end
					end
				end
			end
			default: begin
				if (!rx_dv) begin
					state <= IDLE;
					ofs <= '0;
				end else if (ofs != HDR_LEN) begin
					ofs <= ofs + 1'b1;
				end
			end
		endcase
	end
end

// per-byte flags ride along with the data
always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		dly_fwd <= '0;
		dly_pl <= '0;
		pl_prev <= 1'b0;
	end else begin
		dly_fwd[0] <= in_fwd;
		dly_pl[0] <= in_pl;
		for (int k = 1; k < PIPE_LAT; k++) begin
			// an accept marks the header bytes already queued for this frame
			dly_fwd[k] <= dly_fwd[k-1] || (accept_now && (k <= OFS_DECIDE));
			dly_pl[k] <= dly_pl[k-1];
		end
		pl_prev <= fwd_en && fwd_pl;
	end
end

// payload bytes enter after the decision, so accept_slot is already set
always_ff @(posedge clk) begin
	dly_data[0] <= rxd;
	dly_slot[0] <= accept_slot;
	for (int k = 1; k < PIPE_LAT; k++) begin
		dly_data[k] <= dly_data[k-1];
		dly_slot[k] <= dly_slot[k-1];
	end
end

assign fwd_data = dly_data[PIPE_LAT-1];
assign fwd_en = dly_fwd[PIPE_LAT-1];
assign fwd_pl = dly_pl[PIPE_LAT-1];

// client stream, accepted payload only
assign pl.pl_data = fwd_data;
assign pl.pl_stb = fwd_en && fwd_pl;
assign pl.pl_sop = fwd_en && fwd_pl && !pl_prev;
assign pl.pl_slot = dly_slot[PIPE_LAT-1];

endmodule

/* tb_udp_blob.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// drives udp_blob with fixed layout frames, seed 46
// outputs are sampled on the falling edge
// expected cycles assume a 43 cycle rx to tx latency
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
module tb_udp_blob;

localparam int PERIOD = 40;
localparam int HDR = 42;
localparam int DECIDE = 37;
localparam int LATENCY = 43;
// 14 frames of at most 74 bytes, each followed by a drain
localparam int LIMIT = 2 * (14 * (HDR + 32 + LATENCY + 6) + 300);

logic clk, arst_n;
logic [7:0] rxd, config_d, txd;
logic rx_dv, rx_er, enable_rx, config_s, config_p;
logic [3:0] config_a;
logic tx_en, tx_er, accept_stb, drop_stb;
logic [0:0] accept_slot;

int seed = 46;
int cyc = 0;
int errors = 0;
int ntests = 0;
int nfail = 0;
int last_cyc = 0;
// frame under construction
logic [7:0] frame [0:127];
int frame_len;
// mirror of the configuration registers
logic [47:0] mac_cfg = 48'h12_55_55_00_01_2d;
logic [31:0] ip_cfg = {8'd192, 8'd168, 8'd7, 8'd4};
logic [15:0] port0_cfg = 16'd801;
logic [15:0] port1_cfg = 16'd802;
// decision codes: 0 drop, 1 slot 0, 2 slot 1
int exp_code[$], exp_dcyc[$], got_code[$], got_dcyc[$];
logic [7:0] exp_data[$], got_data[$];
int exp_cyc[$], got_cyc[$];

udp_blob uut (
	.clk(clk), .arst_n(arst_n), .rxd(rxd), .rx_dv(rx_dv), .rx_er(rx_er),
	.enable_rx(enable_rx), .config_a(config_a), .config_d(config_d),
	.config_s(config_s), .config_p(config_p), .txd(txd), .tx_en(tx_en),
	.tx_er(tx_er), .accept_stb(accept_stb), .drop_stb(drop_stb),
	.accept_slot(accept_slot)
);

// cycle count moves just before the rising edge
initial begin
	clk = 1'b0;
	forever begin
		#(PERIOD / 2);
		cyc = cyc + 1;
		clk = 1'b1;
		#(PERIOD / 2);
		clk = 1'b0;
	end
end

// watchdog
initial begin
	#(LIMIT * PERIOD);
	$display("run timed out after %0d cycles, the DUT stopped answering", LIMIT);
	$display("TESTBENCH FAILED");
	$finish;
end

// monitor, outputs are stable at the falling edge
always @(negedge clk) begin
	if (tx_en) begin
		got_data.push_back(txd);
		got_cyc.push_back(cyc);
	end
	if (accept_stb) begin
		got_code.push_back(int'(accept_slot) + 1);
		got_dcyc.push_back(cyc);
	end
	if (drop_stb) begin
		got_code.push_back(0);
		got_dcyc.push_back(cyc);
	end
	assert (tx_er == 1'b0) else begin
		$display("FAIL tx_er expected 0x0 got 0x%h", tx_er);
		errors++;
	end
end

// random frame with the header fields overwritten
task automatic build_frame(input logic [47:0] mac, input logic [31:0] ip,
		input logic [15:0] port, input logic [15:0] etype, input logic [7:0] proto);
	frame_len = HDR + 1 + ($random(seed) & 31);
	for (int i = 0; i < frame_len; i++) begin
		frame[i] = 8'($random(seed));
	end
	for (int i = 0; i < 6; i++) begin
		frame[i] = mac[8 * (5 - i) +: 8];
	end
	frame[12] = etype[15:8];
	frame[13] = etype[7:0];
	frame[14] = 8'h45;
	frame[23] = proto;
	for (int i = 0; i < 4; i++) begin
		frame[30 + i] = ip[8 * (3 - i) +: 8];
	end
	frame[36] = port[15:8];
	frame[37] = port[7:0];
endtask

// reference model of the accept rules, slot 0 wins a double match
function automatic int expect_code(input int er_pos, input logic en);
	logic [47:0] mac;
	logic [31:0] ip;
	logic [15:0] port;
	mac = {frame[0], frame[1], frame[2], frame[3], frame[4], frame[5]};
	ip = {frame[30], frame[31], frame[32], frame[33]};
	port = {frame[36], frame[37]};
	if (!en || (er_pos >= 0 && er_pos <= DECIDE)) return 0;
	if (mac != mac_cfg || {frame[12], frame[13]} != 16'h0800) return 0;
	if (frame[23] != 8'd17 || ip != ip_cfg) return 0;
	if (port == port0_cfg) return 1;
	if (port == port1_cfg) return 2;
	return 0;
endfunction

// plays the frame and queues what the DUT should answer
task automatic play_frame(input int er_pos, input logic en);
	int code;
	logic [7:0] sum;
	logic [7:0] b;
	code = expect_code(er_pos, en);
	sum = 8'h00;
	for (int i = 0; i < frame_len; i++) begin
		@(posedge clk);
		rxd <= frame[i];
		rx_dv <= 1'b1;
		rx_er <= (i == er_pos);
		enable_rx <= en;
		if (i == DECIDE) begin
			exp_code.push_back(code);
			exp_dcyc.push_back(cyc + 1);
		end
		if (code != 0) begin
			if (i < HDR) begin
				b = frame[i];
			end else if (code == 1) begin
				b = frame[i] + 8'(i - HDR);
			end else begin
				sum = sum + frame[i];
				b = sum;
			end
			exp_data.push_back(b);
			exp_cyc.push_back(cyc + LATENCY);
		end
	end
	last_cyc = cyc;
	// one idle cycle before the next frame
	@(posedge clk);
	rxd <= 8'h00;
	rx_dv <= 1'b0;
	rx_er <= 1'b0;
	enable_rx <= 1'b1;
endtask

// wait for every decision, then for the last byte to leave
task automatic wait_drain();
	while (got_code.size() < exp_code.size()) @(negedge clk);
	while (cyc < last_cyc + LATENCY + 3) @(negedge clk);
endtask

task automatic write_cfg(input logic s, input logic p, input logic [3:0] a, input logic [7:0] d);
	@(posedge clk);
	config_s <= s;
	config_p <= p;
	config_a <= a;
	config_d <= d;
	@(posedge clk);
	config_s <= 1'b0;
	config_p <= 1'b0;
endtask

task automatic check_test(input string name);
	int err0;
	int n;
	err0 = errors;
	ntests++;
	assert (got_code.size() == exp_code.size()) else begin
		$display("wrong number of decisions: expected %0d, got %0d",
			exp_code.size(), got_code.size());
		errors++;
	end
	n = (got_code.size() < exp_code.size()) ? got_code.size() : exp_code.size();
	for (int i = 0; i < n; i++) begin
		assert ((got_code[i] != 0) == (exp_code[i] != 0)) else begin
			$display("FAIL accept_stb expected 0x%h got 0x%h", exp_code[i] != 0, got_code[i] != 0);
			errors++;
		end
		assert (got_code[i] == 0 || exp_code[i] == 0 || got_code[i] == exp_code[i]) else begin
			$display("FAIL accept_slot expected 0x%h got 0x%h", exp_code[i] - 1, got_code[i] - 1);
			errors++;
		end
		assert (got_dcyc[i] == exp_dcyc[i]) else begin
			$display("decision strobe came at cycle %0d, expected cycle %0d", got_dcyc[i], exp_dcyc[i]);
			errors++;
		end
	end
	assert (got_data.size() == exp_data.size()) else begin
		$display("wrong number of tx bytes: expected %0d, got %0d", exp_data.size(), got_data.size());
		errors++;
	end
	n = (got_data.size() < exp_data.size()) ? got_data.size() : exp_data.size();
	for (int i = 0; i < n; i++) begin
		assert (got_data[i] == exp_data[i]) else begin
			$display("FAIL txd expected 0x%h got 0x%h", exp_data[i], got_data[i]);
			errors++;
		end
		assert (got_cyc[i] == exp_cyc[i]) else begin
			$display("tx byte %0d came at cycle %0d, expected cycle %0d", i, got_cyc[i], exp_cyc[i]);
			errors++;
		end
	end
	if (errors != err0) nfail++;
	$display("test %0d %s: %s", ntests, name, (errors == err0) ? "ok" : "mismatch");
	exp_code.delete();
	exp_dcyc.delete();
	got_code.delete();
	got_dcyc.delete();
	exp_data.delete();
	exp_cyc.delete();
	got_data.delete();
	got_cyc.delete();
endtask

initial begin
	arst_n = 1'b0;
	rxd = 8'h00;
	rx_dv = 1'b0;
	rx_er = 1'b0;
	enable_rx = 1'b1;
	config_a = 4'h0;
	config_d = 8'h00;
	config_s = 1'b0;
	config_p = 1'b0;
	repeat (10) @(posedge clk);
	arst_n <= 1'b1;
	// no tx_en may show up before any frame
	repeat (50) @(negedge clk);
	check_test("quiet after reset");

	build_frame(mac_cfg, ip_cfg, 16'd801, 16'h0800, 8'd17);
	play_frame(-1, 1'b1);
	wait_drain();
	check_test("slot 0 frame on port 801");
	// second frame restarts the sum, then the index
	for (int k = 0; k < 2; k++) begin
		build_frame(mac_cfg, ip_cfg, 16'd802, 16'h0800, 8'd17);
		play_frame(-1, 1'b1);
	end
	wait_drain();
	check_test("slot 1 frames back to back");
	for (int k = 0; k < 2; k++) begin
		build_frame(mac_cfg, ip_cfg, 16'd801, 16'h0800, 8'd17);
		play_frame(-1, 1'b1);
	end
	wait_drain();
	check_test("slot 0 frames back to back");

	// drop cases
	build_frame(mac_cfg ^ 48'h1, ip_cfg, 16'd801, 16'h0800, 8'd17);
	play_frame(-1, 1'b1);
	wait_drain();
	check_test("wrong MAC");
	build_frame(mac_cfg, ip_cfg ^ 32'h100, 16'd801, 16'h0800, 8'd17);
	play_frame(-1, 1'b1);
	wait_drain();
	check_test("wrong IP");
	build_frame(mac_cfg, ip_cfg, 16'd801, 16'h0806, 8'd17);
	play_frame(-1, 1'b1);
	wait_drain();
	check_test("wrong ethertype");
	build_frame(mac_cfg, ip_cfg, 16'd802, 16'h0800, 8'd6);
	play_frame(-1, 1'b1);
	wait_drain();
	check_test("protocol not UDP");
	build_frame(mac_cfg, ip_cfg, 16'd803, 16'h0800, 8'd17);
	play_frame(-1, 1'b1);
	wait_drain();
	check_test("unmatched port");
	build_frame(mac_cfg, ip_cfg, 16'd801, 16'h0800, 8'd17);
	play_frame(20, 1'b1);
	wait_drain();
	check_test("rx_er in header");
	build_frame(mac_cfg, ip_cfg, 16'd801, 16'h0800, 8'd17);
	play_frame(-1, 1'b0);
	wait_drain();
	check_test("enable_rx low");

	// new MAC, IP and slot 1 port, MAC and IP msb first
	for (int i = 0; i < 6; i++) begin
		write_cfg(1'b1, 1'b0, 4'(i), 8'h02 + 8'(17 * i));
	end
	for (int i = 0; i < 4; i++) begin
		write_cfg(1'b1, 1'b0, 4'(6 + i), 8'h0a + 8'(i));
	end
	write_cfg(1'b0, 1'b1, 4'h2, 8'h13);
	write_cfg(1'b0, 1'b1, 4'h3, 8'h88);
	build_frame(mac_cfg, ip_cfg, port1_cfg, 16'h0800, 8'd17);
	mac_cfg = 48'h02_13_24_35_46_57;
	ip_cfg = 32'h0a_0b_0c_0d;
	port1_cfg = 16'h1388;
	play_frame(-1, 1'b1);
	build_frame(mac_cfg, ip_cfg, port1_cfg, 16'h0800, 8'd17);
	play_frame(-1, 1'b1);
	wait_drain();
	check_test("config update, old then new values");

	$display("tests run: %0d, tests failed: %0d, checks failed: %0d", ntests, nfail, errors);
	if (errors == 0) begin
		$display("TESTBENCH PASSED");
	end else begin
		$display("TESTBENCH FAILED");
	end
	$finish;
end

endmodule

/* tx_framer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// header bytes pass through, payload comes from the client
// bound to the frame's slot
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
module tx_framer import udp_pkg::*; (
	input logic clk,
	input logic arst_n,
	client_if.framer pl,
	input byte_t fwd_data,
	input logic fwd_en,
	input logic fwd_pl,
	output byte_t txd,
	output logic tx_en
);

// forward stream delayed to line up with the clients
byte_t d_data [CLIENT_LAT];
slot_t d_slot [CLIENT_LAT];
logic [CLIENT_LAT-1:0] d_en, d_pl;

// client results indexed by slot
byte_t client_out [N_SLOTS];

assign client_out[SLOT_COUNT] = pl.out_count;
assign client_out[SLOT_ACCUM] = pl.out_accum;

always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		d_en <= '0;
		d_pl <= '0;
	end else begin
		d_en <= {d_en[CLIENT_LAT-2:0], fwd_en};
		d_pl <= {d_pl[CLIENT_LAT-2:0], fwd_pl};
	end
end

// data and slot delay line
always_ff @(posedge clk) begin
	d_data[0] <= fwd_data;
	d_slot[0] <= pl.pl_slot;
	for (int k = 1; k < CLIENT_LAT; k++) begin
		d_data[k] <= d_data[k-1];
		d_slot[k] <= d_slot[k-1];
	end
end

// byte mux
assign txd = d_pl[CLIENT_LAT-1] ? client_out[d_slot[CLIENT_LAT-1]] : d_data[CLIENT_LAT-1];
assign tx_en = d_en[CLIENT_LAT-1];

endmodule

/* udp_blob.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// single clock, no CDC, no back-pressure
// accepted frame leaves PIPE_LAT + CLIENT_LAT cycles after rx
// tx_er is always low
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
module udp_blob import udp_pkg::*; (
	input logic clk,
	input logic arst_n,
	// GMII style rx
	input byte_t rxd,
	input logic rx_dv,
	input logic rx_er,
	input logic enable_rx,
	// configuration
	input logic [3:0] config_a,
	input byte_t config_d,
	input logic config_s,
	input logic config_p,
	// GMII style tx
	output byte_t txd,
	output logic tx_en,
	output logic tx_er,
	// frame decision
	output logic accept_stb,
	output logic drop_stb,
	output slot_t accept_slot
);

mac_t cfg_mac;
ip_t cfg_ip;
port_t cfg_port0, cfg_port1;
byte_t fwd_data;
logic fwd_en, fwd_pl;

client_if pl_bus ();

udp_config config_regs (
	.clk(clk), .arst_n(arst_n),
	.config_a(config_a), .config_d(config_d),
	.config_s(config_s), .config_p(config_p),
	.cfg_mac(cfg_mac), .cfg_ip(cfg_ip),
	.cfg_port0(cfg_port0), .cfg_port1(cfg_port1)
);

rx_scanner scanner (
	.clk(clk), .arst_n(arst_n),
	.rxd(rxd), .rx_dv(rx_dv), .rx_er(rx_er), .enable_rx(enable_rx),
	.cfg_mac(cfg_mac), .cfg_ip(cfg_ip),
	.cfg_port0(cfg_port0), .cfg_port1(cfg_port1),
	.pl(pl_bus.scanner),
	.fwd_data(fwd_data), .fwd_en(fwd_en), .fwd_pl(fwd_pl),
	.accept_stb(accept_stb), .drop_stb(drop_stb), .accept_slot(accept_slot)
);

// slot 0 and slot 1 clients
client_count count (.clk(clk), .arst_n(arst_n), .pl(pl_bus.count_client));
client_accum accum (.clk(clk), .arst_n(arst_n), .pl(pl_bus.accum_client));

tx_framer framer (
	.clk(clk), .arst_n(arst_n),
	.pl(pl_bus.framer),
	.fwd_data(fwd_data), .fwd_en(fwd_en), .fwd_pl(fwd_pl),
	.txd(txd), .tx_en(tx_en)
);

assign tx_er = 1'b0;

endmodule

/* udp_config.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one byte per write strobe, new value visible next cycle
// undefined addresses are ignored
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
module udp_config import udp_pkg::*; (
	input logic clk,
	input logic arst_n,
	input logic [3:0] config_a,
	input byte_t config_d,
	// MAC/IP address write
	input logic config_s,
	// UDP port number write
	input logic config_p,
	output mac_t cfg_mac,
	output ip_t cfg_ip,
	output port_t cfg_port0,
	output port_t cfg_port1
);

logic mac_wr, ip_wr, port_wr;

// address decode
assign mac_wr = config_s && (config_a < CFG_A_IP);
assign ip_wr = config_s && (config_a >= CFG_A_IP) && (config_a < CFG_A_END);
// port writes only use a[1:0], upper bits must be zero
assign port_wr = config_p && (config_a[3:2] == 2'b00);

always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		cfg_mac <= DEF_MAC;
		cfg_ip <= DEF_IP;
		cfg_port0 <= DEF_PORT0;
		cfg_port1 <= DEF_PORT1;
	end else begin
		// lowest address is the most significant byte
		if (mac_wr) begin
			cfg_mac[8 * (CFG_A_IP - 1 - config_a) +: 8] <= config_d;
		end
		if (ip_wr) begin
			cfg_ip[8 * (CFG_A_END - 1 - config_a) +: 8] <= config_d;
		end
		if (port_wr) begin
			// a[1] picks the slot, a[0] the low byte
			case (config_a[1:0])
				2'b00: cfg_port0[15:8] <= config_d;
				2'b01: cfg_port0[7:0] <= config_d;
				2'b10: cfg_port1[15:8] <= config_d;
				default: cfg_port1[7:0] <= config_d;
			endcase
		end
	end
end

endmodule

/* udp_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fixed frame layout: no preamble, no FCS, no IPv4 options
// PIPE_LAT must stay above OFS_DECIDE, so that a frame is
// judged before its first byte leaves the scanner delay line
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package udp_pkg;

// stream and address widths
typedef logic [7:0] byte_t;
typedef logic [47:0] mac_t;
typedef logic [31:0] ip_t;
typedef logic [15:0] port_t;
typedef logic [0:0] slot_t;
typedef logic [5:0] offset_t;

// client slots, slot 0 has priority if both ports match
localparam int N_SLOTS = 2;
localparam slot_t SLOT_COUNT = 1'b0;
localparam slot_t SLOT_ACCUM = 1'b1;

// latencies in clk cycles
localparam int PIPE_LAT = 40;
localparam int CLIENT_LAT = 3;

// header is eth 14 + ipv4 20 + udp 8
localparam int HDR_LEN = 42;
localparam int OFS_DMAC = 0;
localparam int OFS_ETYPE = 12;
localparam int OFS_PROTO = 23;
localparam int OFS_DIP = 30;
localparam int OFS_DPORT = 36;
// last header byte that takes part in the decision
localparam int OFS_DECIDE = 37;

// expected field values
localparam byte_t ETYPE_HI = 8'h08;
localparam byte_t ETYPE_LO = 8'h00;
localparam byte_t PROTO_UDP = 8'd17;

// config_s address map: MAC at 0..5, IP at 6..9
localparam int CFG_A_IP = 6;
localparam int CFG_A_END = 10;

// values loaded at reset
localparam mac_t DEF_MAC = 48'h12_55_55_00_01_2d;
localparam ip_t DEF_IP = {8'd192, 8'd168, 8'd7, 8'd4};
localparam port_t DEF_PORT0 = 16'd801;
localparam port_t DEF_PORT1 = 16'd802;

typedef enum logic [1:0] {IDLE, HEADER, FORWARD, DISCARD} scan_state_e;

endpackage
